// File: src/isaConsts.svh
// Aligner size constants
`ifndef ISA_CONSTS_SVH
`define ISA_CONSTS_SVH

// ==============================
// Queue and fetch sizes
// ==============================

// Byte capacity of the alignment queue
`define QUEUE_BYTES 16

// Bytes delivered by one fetch push
`define FETCH_BYTES 4

// ==============================
// Instruction sizes
// ==============================

// Longest instruction in bytes, also the width of the head window
`define MAX_INS_BYTES 8

// Bits needed for a byte count of 1 to 8
`define LEN_BITS 4

// Bits needed for a fill count of 0 to 16
`define FILL_BITS 5

`endif

// File: src/isaPkg.sv
// Instruction set definitions
`include "isaConsts.svh"

package isaPkg;

  // ==============================
  // Opcode keys
  // ==============================

  // Each key is the 9-bit value {v, opcode} that the length decoder matches
  // The vector bit is zero in every key listed here

  // Breakpoint, the only two-byte opcode in the low page
  localparam logic [8:0] BRK   = 9'h000;

  // Long immediate forms carry a 32-bit constant and take seven bytes
  localparam logic [8:0] ADDIL = 9'h00C;
  localparam logic [8:0] ANDIL = 9'h00D;
  localparam logic [8:0] ORIL  = 9'h00E;
  localparam logic [8:0] XORIL = 9'h00F;

  // Group bases, the low nibble selects the condition or the access size
  localparam logic [8:0] BCC   = 9'h020;
  localparam logic [8:0] BCCL  = 9'h030;
  localparam logic [8:0] LD    = 9'h080;
  localparam logic [8:0] ST    = 9'h090;
  localparam logic [8:0] LDL   = 9'h0D0;
  localparam logic [8:0] STL   = 9'h0E0;

  // System page, all of these are two bytes long
  localparam logic [8:0] NOP   = 9'h0F0;
  localparam logic [8:0] RTS   = 9'h0F1;
  localparam logic [8:0] RTE   = 9'h0F2;
  localparam logic [8:0] SYNC  = 9'h0F3;
  localparam logic [8:0] WFI   = 9'h0F4;
  localparam logic [8:0] SEI   = 9'h0F5;

  // ==============================
  // Instruction word views
  // ==============================

  // Decode view shared by every format
  // Bit 8 is the vector bit when the instruction has a second byte
  typedef struct packed {
    logic [`MAX_INS_BYTES*8-10:0] rest;
    logic                         v;
    logic [7:0]                   opcode;
  } AnyView;

  // Register format view
  // The destination field overlaps the vector bit position
  typedef struct packed {
    logic [`MAX_INS_BYTES*8-27:0] rest;
    logic [5:0]                   rb;
    logic [5:0]                   ra;
    logic [5:0]                   rd;
    logic [7:0]                   opcode;
  } RegView;

  // First eight instruction bytes with byte 0 in the lowest bits
  typedef union packed {
    AnyView any;
    RegView regs;
  } Instruction;

endpackage

// File: src/fetchPkg.sv
// Fetch path types

package fetchPkg;

  // ==============================
  // Instruction classes
  // ==============================

  // Coarse class attached to each aligned instruction
  // Later stages use it to steer the instruction to a unit
  typedef enum logic [1:0] {
    // Integer and logic operations, the default for unlisted opcodes
    ALU    = 2'd0,
    // Short and long branches
    BRANCH = 2'd1,
    // Loads and stores of every size
    MEMORY = 2'd2,
    // Breakpoint and the system page
    SYSTEM = 2'd3
  } InsClass;

endpackage

// File: src/byteQueue.sv
// Code byte queue
`timescale 1ns/1ps
`include "isaConsts.svh"

module byteQueue (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        flush,
  input  logic                        fetchValid,
  input  logic [`FETCH_BYTES*8-1:0]   fetchBytes,
  output logic                        fetchReady,
  input  logic [`LEN_BITS-1:0]        popCount,
  output logic [`MAX_INS_BYTES*8-1:0] headBytes,
  output logic [`FILL_BITS-1:0]       fillCount
);

  // Byte 0 of the array is always the oldest byte in the queue
  logic [7:0]            mem     [`QUEUE_BYTES];
  logic [7:0]            memNext [`QUEUE_BYTES];
  logic [`FILL_BITS-1:0] fill;
  logic [`FILL_BITS-1:0] remain;
  logic                  push;

  assign fillCount = fill;

  // Room for a whole fetch word is required before a push is taken
  assign fetchReady = fill <= (`QUEUE_BYTES - `FETCH_BYTES);
  assign push       = fetchValid && fetchReady;

  // Bytes still held after this cycle's pop
  assign remain = fill - {1'b0, popCount};

  // ==============================
  // Head window
  // ==============================

  // Empty slots read as zero so the decoders see a clean window
  always_comb begin
    for (int i = 0; i < `MAX_INS_BYTES; i++) begin
      headBytes[i*8 +: 8] = (i < fill) ? mem[i] : 8'h00;
    end
  end

  // ==============================
  // Shift and append
  // ==============================

  always_comb begin
    for (int i = 0; i < `QUEUE_BYTES; i++) begin
      // The pop moves every surviving byte down by popCount places
      if (i + popCount < `QUEUE_BYTES) begin
        memNext[i] = mem[i + popCount];
      end else begin
        memNext[i] = 8'h00;
      end
      // The new word lands right behind the surviving bytes
      if (push && i >= remain && i < remain + `FETCH_BYTES) begin
        memNext[i] = fetchBytes[(i - remain)*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `QUEUE_BYTES; i++) begin
      mem[i] <= memNext[i];
    end
  end

  // Flush drops the contents and any push offered in the same cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fill <= '0;
    end else if (flush) begin
      fill <= '0;
    end else begin
      fill <= remain + (push ? `FILL_BITS'(`FETCH_BYTES) : '0);
    end
  end

  // The extractor never asks for more bytes than the queue holds
  assert property (@(posedge clk) disable iff (!rstN) popCount <= fillCount);

  // The fill never runs past the end of the array
  assert property (@(posedge clk) disable iff (!rstN) fill <= `QUEUE_BYTES);

endmodule

// File: src/insLength.sv
// Instruction length decoder
`timescale 1ns/1ps

module insLength (
  input  isaPkg::Instruction ir,
  output logic [3:0]         len
);

  // ==============================
  // Length table
  // ==============================

  // The key is the vector bit joined to the opcode
  // Items are matched in order, so the specific opcodes sit above the
  // wildcard pages that would otherwise cover them
  always_comb begin
    casez ({ir.any.v, ir.any.opcode})
      // Breakpoint carries a one-byte cause code
      isaPkg::BRK: begin
        len = 4'd2;
      end
      // Long immediates take a full 32-bit constant
      isaPkg::ADDIL,
      isaPkg::ANDIL,
      isaPkg::ORIL,
      isaPkg::XORIL: begin
        len = 4'd7;
      end
      // Register and short immediate ALU forms in the low two pages
      9'h00?,
      9'h01?: begin
        len = 4'd4;
      end
      // Branches with a short displacement
      9'h02?: begin
        len = 4'd5;
      end
      // Long branches
      9'h03?: begin
        len = 4'd7;
      end
      // Scalar loads and stores
      9'h08?,
      9'h09?: begin
        len = 4'd4;
      end
      // Vector loads and stores need an extra mask field
      9'h18?,
      9'h19?: begin
        len = 4'd6;
      end
      // Loads and stores with a long displacement
      9'h0D?,
      9'h0E?: begin
        len = 4'd7;
      end
      // System page
      isaPkg::NOP,
      isaPkg::RTS,
      isaPkg::RTE,
      isaPkg::SYNC,
      isaPkg::WFI,
      isaPkg::SEI: begin
        len = 4'd2;
      end
      // Everything else is a single byte, including any unlisted opcode
      // that happens to see a set bit 8 from the byte behind it
      default: begin
        len = 4'd1;
      end
    endcase
  end

endmodule

// File: src/insClassify.sv
// Instruction class decoder
`timescale 1ns/1ps

module insClassify (
  input  isaPkg::Instruction ir,
  output fetchPkg::InsClass  insClass,
  output logic               vector
);

  // ==============================
  // Class table
  // ==============================

  // Only the opcode byte matters here, the vector bit plays no part
  always_comb begin
    if (ir.any.opcode == isaPkg::BRK[7:0]) begin
      // Breakpoint shares the system class with the F page
      insClass = fetchPkg::SYSTEM;
    end else begin
      case (ir.any.opcode[7:4])
        isaPkg::BCC[7:4],
        isaPkg::BCCL[7:4]: begin
          insClass = fetchPkg::BRANCH;
        end
        isaPkg::LD[7:4],
        isaPkg::ST[7:4],
        isaPkg::LDL[7:4],
        isaPkg::STL[7:4]: begin
          insClass = fetchPkg::MEMORY;
        end
        isaPkg::NOP[7:4]: begin
          insClass = fetchPkg::SYSTEM;
        end
        default: begin
          insClass = fetchPkg::ALU;
        end
      endcase
    end
  end

  // Raw bit 8 of the window
  // It is only meaningful once the length shows a second byte exists
  assign vector = ir.any.v;

endmodule

// File: src/insExtract.sv
// Instruction extractor
`timescale 1ns/1ps
`include "isaConsts.svh"

module insExtract (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        stall,
  input  logic                        flush,
  input  logic [`MAX_INS_BYTES*8-1:0] headBytes,
  input  logic [`FILL_BITS-1:0]       fillCount,
  input  logic [`LEN_BITS-1:0]        len,
  input  fetchPkg::InsClass           insClass,
  input  logic                        vector,
  output logic [`LEN_BITS-1:0]        popCount,
  output logic                        insValid,
  output logic [`MAX_INS_BYTES*8-1:0] insWord,
  output logic [`LEN_BITS-1:0]        insLength,
  output fetchPkg::InsClass           insClassOut,
  output logic                        insVector
);

  logic                        emit;
  logic [`MAX_INS_BYTES*8-1:0] maskedWord;

  // ==============================
  // Emit decision
  // ==============================

  // The head instruction leaves once every one of its bytes has arrived
  assign emit     = !stall && !flush && (fillCount >= {1'b0, len});
  assign popCount = emit ? len : '0;

  // Bytes past the decoded length belong to the next instruction
  always_comb begin
    for (int i = 0; i < `MAX_INS_BYTES; i++) begin
      maskedWord[i*8 +: 8] = (i < len) ? headBytes[i*8 +: 8] : 8'h00;
    end
  end

  // ==============================
  // Output stage
  // ==============================

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      insValid <= 1'b0;
    end else begin
      insValid <= emit;
    end
  end

  // Attributes are only loaded with a real instruction
  always_ff @(posedge clk) begin
    if (emit) begin
      insWord     <= maskedWord;
      insLength   <= len;
      insClassOut <= insClass;
      // A one-byte instruction has no bit 8 of its own
      insVector   <= vector && (len > 4'd1);
    end
  end

  // Every registered instruction has a length the decoder can produce
  assert property (@(posedge clk) disable iff (!rstN)
    insValid |-> insLength inside {[4'd1:4'd8]});

  // A stalled cycle pops nothing, so the oldest byte stays at the head
  assert property (@(posedge clk) disable iff (!rstN)
    stall && !flush && fillCount != '0 |=> headBytes[7:0] == $past(headBytes[7:0]));

endmodule

// File: src/insAligner.sv
// Instruction aligner top level
`timescale 1ns/1ps
`include "isaConsts.svh"

module insAligner (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        flush,
  input  logic                        stall,
  input  logic                        fetchValid,
  input  logic [`FETCH_BYTES*8-1:0]   fetchBytes,
  output logic                        fetchReady,
  output logic                        insValid,
  output logic [`MAX_INS_BYTES*8-1:0] insWord,
  output logic [`LEN_BITS-1:0]        insLength,
  output fetchPkg::InsClass           insClass,
  output logic                        insVector
);

  logic [`MAX_INS_BYTES*8-1:0] headBytes;
  logic [`FILL_BITS-1:0]       fillCount;
  logic [`LEN_BITS-1:0]        popCount;
  logic [`LEN_BITS-1:0]        headLen;
  fetchPkg::InsClass           headClass;
  logic                        headVector;

  // ==============================
  // Queue and decoders
  // ==============================

  byteQueue uQueue (
    .clk        (clk),
    .rstN       (rstN),
    .flush      (flush),
    .fetchValid (fetchValid),
    .fetchBytes (fetchBytes),
    .fetchReady (fetchReady),
    .popCount   (popCount),
    .headBytes  (headBytes),
    .fillCount  (fillCount)
  );

  // Both decoders look at the same head window in parallel
  insLength uLength (
    .ir  (headBytes),
    .len (headLen)
  );

  insClassify uClassify (
    .ir       (headBytes),
    .insClass (headClass),
    .vector   (headVector)
  );

  // ==============================
  // Extractor
  // ==============================

  insExtract uExtract (
    .clk         (clk),
    .rstN        (rstN),
    .stall       (stall),
    .flush       (flush),
    .headBytes   (headBytes),
    .fillCount   (fillCount),
    .len         (headLen),
    .insClass    (headClass),
    .vector      (headVector),
    .popCount    (popCount),
    .insValid    (insValid),
    .insWord     (insWord),
    .insLength   (insLength),
    .insClassOut (insClass),
    .insVector   (insVector)
  );

endmodule

// File: bench/insAlignerTb.sv
// Instruction aligner testbench
`timescale 1ns/1ps
`include "isaConsts.svh"

module insAlignerTb;

  localparam int period = 100;
  localparam int resetCycles = 16;
  // Three passes over one random stream, the flush test, directed cases and padding
  localparam int totalIns = 300 * 3 + 300 + 40;
  localparam int watchdogCycles = 20 * totalIns + resetCycles;

  // {v, opcode} keys for the directed stream
  // The tail pairs one-byte opcodes with an odd opcode behind them
  localparam logic [8:0] directedKeys [24] = '{
    9'h000, 9'h005, 9'h00C, 9'h00F, 9'h017, 9'h023, 9'h031, 9'h084,
    9'h185, 9'h19A, 9'h097, 9'h0D2, 9'h0E6, 9'h0F0, 9'h0F3, 9'h0F5,
    9'h140, 9'h105, 9'h041, 9'h100, 9'h1F1, 9'h0C3, 9'h07E, 9'h0F9
  };

  // Expected attributes of one aligned instruction
  typedef struct packed {
    logic [`MAX_INS_BYTES*8-1:0] word;
    logic [3:0]                  len;
    fetchPkg::InsClass           cls;
    logic                        vec;
  } ExpRec;

  logic                        clk;
  logic                        rstN;
  logic                        flush;
  logic                        stall;
  logic                        fetchValid;
  logic [`FETCH_BYTES*8-1:0]   fetchBytes;
  logic                        fetchReady;
  logic                        insValid;
  logic [`MAX_INS_BYTES*8-1:0] insWord;
  logic [3:0]                  insLength;
  fetchPkg::InsClass           insClass;
  logic                        insVector;

  logic [31:0] seed;
  logic [7:0]  stream [$];
  ExpRec       expQ [$];
  ExpRec       expNow;
  int          pushIdx;
  bit          needOdd;
  bit          stallAtEdge;
  bit          sawNotReady;
  logic [8:0]  lenSeen;
  string       testName;

  insAligner dut (
    .clk        (clk),
    .rstN       (rstN),
    .flush      (flush),
    .stall      (stall),
    .fetchValid (fetchValid),
    .fetchBytes (fetchBytes),
    .fetchReady (fetchReady),
    .insValid   (insValid),
    .insWord    (insWord),
    .insLength  (insLength),
    .insClass   (insClass),
    .insVector  (insVector)
  );

  initial clk = 1'b0;
  always #(period / 2) clk = ~clk;

  // ==============================
  // Random source and reference
  // ==============================

  function automatic logic [31:0] lcgNext();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [7:0] randByte();
    logic [31:0] r;
    r = lcgNext();
    return r[23:16];
  endfunction

  function automatic int randPct();
    logic [31:0] r;
    r = lcgNext();
    return int'(r[31:16]) % 100;
  endfunction

  // Byte count from the opcode and the vector bit
  function automatic logic [3:0] refLen(logic [7:0] op, logic v);
    if (v) begin
      // Only the load and store pages have a vector form, anything else is one byte
      return (op[7:4] == 4'h8 || op[7:4] == 4'h9) ? 4'd6 : 4'd1;
    end
    case (op[7:4])
      4'h0: return (op == 8'h00) ? 4'd2 : (op[3:2] == 2'b11) ? 4'd7 : 4'd4;
      4'h1: return 4'd4;
      4'h2: return 4'd5;
      4'h3, 4'hD, 4'hE: return 4'd7;
      4'h8, 4'h9: return 4'd4;
      4'hF: return (op[3:0] <= 4'h5) ? 4'd2 : 4'd1;
      default: return 4'd1;
    endcase
  endfunction

  // Expected record for the instruction that opens the window
  function automatic ExpRec refDecode(logic [`MAX_INS_BYTES*8-1:0] window);
    ExpRec r;
    logic  v;
    v = window[8];
    r.len = refLen(window[7:0], v);
    // A single byte has no bit 8 of its own
    r.vec = v && (r.len >= 4'd2);
    case (window[7:4])
      4'h2, 4'h3: r.cls = fetchPkg::BRANCH;
      4'h8, 4'h9, 4'hD, 4'hE: r.cls = fetchPkg::MEMORY;
      4'hF: r.cls = fetchPkg::SYSTEM;
      default: r.cls = (window[7:0] == 8'h00) ? fetchPkg::SYSTEM : fetchPkg::ALU;
    endcase
    for (int i = 0; i < `MAX_INS_BYTES; i++) begin
      r.word[i*8 +: 8] = (i < int'(r.len)) ? window[i*8 +: 8] : 8'h00;
    end
    return r;
  endfunction

  // ==============================
  // Stream building
  // ==============================

  // A one-byte instruction whose length hangs on v forces an odd opcode next
  function automatic void addIns(logic [7:0] op, logic v);
    logic [3:0] len;
    logic [7:0] b;
    if (needOdd) begin
      op[0] = 1'b1;
    end
    len = refLen(op, v);
    stream.push_back(op);
    if (len == 4'd1) begin
      needOdd = v && (refLen(op, 1'b0) != 4'd1);
    end else begin
      b = randByte();
      stream.push_back({b[7:1], v});
      for (int i = 2; i < int'(len); i++) begin
        stream.push_back(randByte());
      end
      needOdd = 1'b0;
    end
  endfunction

  // Ends on an instruction boundary and pads with one-byte ALU ops to whole words
  function automatic void finishStream();
    if (needOdd) begin
      addIns(8'h41, 1'b0);
    end
    while (stream.size() % `FETCH_BYTES != 0) begin
      addIns(8'h40, 1'b0);
    end
  endfunction

  function automatic void buildRandom(int count);
    logic [7:0] b;
    stream.delete();
    needOdd = 1'b0;
    repeat (count) begin
      b = randByte();
      addIns(randByte(), b[0]);
    end
    finishStream();
  endfunction

  function automatic void buildDirected();
    stream.delete();
    needOdd = 1'b0;
    foreach (directedKeys[i]) begin
      addIns(directedKeys[i][7:0], directedKeys[i][8]);
    end
    finishStream();
  endfunction

  // ==============================
  // Checking
  // ==============================

  task automatic abortRun();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      abortRun();
    end
  endtask

  // Walks the stream from byte 0 the way the queue head advances
  task automatic loadExpected();
    int                          pos;
    logic [`MAX_INS_BYTES*8-1:0] window;
    ExpRec                       r;
    expQ.delete();
    pos = 0;
    while (pos < stream.size()) begin
      window = '0;
      for (int i = 0; i < `MAX_INS_BYTES; i++) begin
        if (pos + i < stream.size()) begin
          window[i*8 +: 8] = stream[pos + i];
        end
      end
      r = refDecode(window);
      expQ.push_back(r);
      pos += int'(r.len);
    end
    if (pos != stream.size()) begin
      $display("The stimulus stream does not end on an instruction boundary");
      abortRun();
    end
  endtask

  always @(posedge clk) begin
    stallAtEdge <= stall;
  end

  // Outputs change on the rising edge and are compared on the falling one
  always @(negedge clk) begin
    if (rstN) begin
      if (stallAtEdge) begin
        check($sformatf("%s stall bubble", testName), 64'd0, 64'(insValid));
      end
      if (insValid) begin
        if (expQ.size() == 0) begin
          $display("Instruction %h came out with nothing left to expect in %s",
                   insWord, testName);
          abortRun();
        end else begin
          expNow = expQ.pop_front();
          lenSeen[expNow.len] = 1'b1;
          check($sformatf("%s word", testName), 64'(expNow.word), 64'(insWord));
          check($sformatf("%s length", testName), 64'(expNow.len), 64'(insLength));
          check($sformatf("%s class", testName), 64'(expNow.cls), 64'(insClass));
          check($sformatf("%s vector", testName), 64'(expNow.vec), 64'(insVector));
        end
      end
    end
  end

  // ==============================
  // Stimulus and test sequence
  // ==============================

  // Pushes words up to stopAt and, for a whole stream, waits until all came out
  task automatic sendStream(int stallPct, int gapPct, int holdStall, int stopAt);
    int cycle;
    cycle = 0;
    pushIdx = 0;
    while (pushIdx < stopAt || (stopAt == stream.size() && expQ.size() != 0)) begin
      @(negedge clk);
      stall = (cycle < holdStall) || (randPct() < stallPct);
      if (stall && !fetchReady) begin
        sawNotReady = 1'b1;
      end
      if (pushIdx < stopAt && fetchReady && randPct() >= gapPct) begin
        fetchValid = 1'b1;
        for (int i = 0; i < `FETCH_BYTES; i++) begin
          fetchBytes[i*8 +: 8] = stream[pushIdx + i];
        end
        pushIdx += `FETCH_BYTES;
      end else begin
        fetchValid = 1'b0;
      end
      cycle++;
    end
    stall = 1'b0;
  endtask

  initial begin
    seed = 32'h7bb8babb;
    rstN = 1'b0;
    flush = 1'b0;
    stall = 1'b0;
    fetchValid = 1'b0;
    fetchBytes = '0;
    sawNotReady = 1'b0;
    lenSeen = '0;
    testName = "reset";
    repeat (resetCycles) @(negedge clk);
    rstN = 1'b1;

    testName = "idle";
    repeat (8) begin
      @(negedge clk);
      check("idle valid", 64'd0, 64'(insValid));
      check("idle ready", 64'd1, 64'(fetchReady));
    end

    // One random stream replayed under three fetch and stall patterns
    testName = "stream";
    buildRandom(300);
    loadExpected();
    sendStream(0, 0, 0, stream.size());

    // A long stall up front lets the queue fill until fetch is held off
    testName = "stall";
    loadExpected();
    sendStream(30, 0, 12, stream.size());
    check("stall backpressure", 64'd1, 64'(sawNotReady));

    testName = "starved";
    loadExpected();
    sendStream(0, 40, 0, stream.size());

    // Flush part way through, then start a new stream on a word boundary
    testName = "flush";
    buildRandom(150);
    loadExpected();
    sendStream(0, 0, 0, (stream.size() / 8) * 4);
    @(negedge clk);
    fetchValid = 1'b0;
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    buildRandom(150);
    loadExpected();
    sendStream(0, 0, 0, stream.size());

    testName = "directed";
    lenSeen = '0;
    buildDirected();
    loadExpected();
    sendStream(0, 0, 0, stream.size());
    check("length groups", 64'h0F6, 64'(lenSeen & 9'h0F6));

    // A few idle cycles catch any extra instruction
    repeat (4) @(negedge clk);
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    #(watchdogCycles * period);
    $display("Timeout: the aligner stopped delivering the expected instructions");
    abortRun();
  end

endmodule

// File: src.f
+incdir+src
src/isaPkg.sv
src/fetchPkg.sv
src/byteQueue.sv
src/insLength.sv
src/insClassify.sv
src/insExtract.sv
src/insAligner.sv
bench/insAlignerTb.sv

// File: Makefile
# Verilator simulation of the instruction aligner

VERILATOR ?= verilator
TOP       ?= insAlignerTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Build and run, then pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
